// File: Bender.yml
package:
  name: fpu_unit

sources:
  - files:
      - design/fpu_pkg.sv
      - design/stage_pipe.sv
      - design/fp_sign_ops.sv
      - design/int_fused_alu.sv
      - design/fp_status_regs.sv
      - design/result_select.sv
      - design/fpu_unit_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/fpu_unit_tb.sv

// File: design/fp_sign_ops.sv
/*
 * Sign injection, sign function and significand extract
 *   computed from the undelayed operands
 *   held for pipe_depth edges to line up with the request
 */

`timescale 1ns/10ps

module fp_sign_ops (
	input  logic               clk,
	input  logic               arst_n,
	input  fpu_pkg::fp64_t     a,
	input  fpu_pkg::fp64_t     b,
	output fpu_pkg::sign_res_t res
);

	import fpu_pkg::*;

	sign_res_t res_c;
	logic      a_zero;
	logic      a_nan;

	assign a_zero = ({a.exp, a.sig} == '0);
	assign a_nan  = (a.exp == exp_max) && (a.sig != '0);

	always_comb
	begin
		// Magnitude of b under a new sign
		res_c.sgnj  = {a.sign, b.exp, b.sig};
		res_c.sgnjn = {~a.sign, b.exp, b.sig};
		res_c.sgnjx = {a.sign ^ b.sign, b.exp, b.sig};

		if (a_zero)
			res_c.sign = '0;
		else if (a_nan)
			res_c.sign = a;                                   // NaN passes through
		else
			res_c.sign = {a.sign, one_bits[data_w-2:0]};      // +/-1.0

		res_c.sig = {{(data_w-sig_w){1'b0}}, a.sig};
	end

	// Two stages to meet the delayed request
	stage_pipe #(
		.payload_t (sign_res_t),
		.depth     (pipe_depth)
	) res_pipe_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.in     (res_c),
		.out    (res)
	);

endmodule

// File: design/fp_status_regs.sv
/*
 * Floating-point status register
 *   rounding mode and class flags of the last float result
 */

`timescale 1ns/10ps

module fp_status_regs (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                status_we,
	input  fpu_pkg::fp_status_t status_next,
	output fpu_pkg::fp_status_t status
);

	import fpu_pkg::*;

	fp_status_t status_q;

	// Loads on the result edge
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			status_q <= '0;
		else if (status_we)
			status_q <= status_next;
	end

	// rm read by the result stage comes from here
	assign status = status_q;

endmodule

// File: design/fpu_pkg.sv
/*
 * Shared definitions for the 64-bit execution unit
 *   width and encoding constants
 *   opcode, function and combine-step encodings
 *   micro-op, request, status and sign result structs
 */

package fpu_pkg;

	// ==================================================
	// Widths and constants
	// ==================================================
	localparam int data_w     = 64;
	localparam int exp_w      = 11;
	localparam int sig_w      = 52;
	localparam int pipe_depth = 2;     // Operand delay ahead of result select

	localparam logic [exp_w-1:0]  exp_max  = 11'd2047;
	localparam logic [data_w-1:0] one_bits = 64'h3FF0_0000_0000_0000;  // +1.0

	// Double precision layout
	typedef struct packed {
		logic             sign;
		logic [exp_w-1:0] exp;
		logic [sig_w-1:0] sig;
	} fp64_t;

	// ==================================================
	// Encodings
	// ==================================================
	typedef enum logic [6:0] {
		op_r3o   = 7'h02,
		op_addi  = 7'h04,
		op_subfi = 7'h05,
		op_andi  = 7'h08,
		op_ori   = 7'h09,
		op_xori  = 7'h0A,
		op_flt   = 7'h50,
		op_nop   = 7'h7F
	} opcode_e;

	// Fused group in the low codes, float group above
	typedef enum logic [6:0] {
		fn_add    = 7'h04,
		fn_and    = 7'h08,
		fn_or     = 7'h09,
		fn_xor    = 7'h0A,
		flt_sgnj  = 7'h10,
		flt_sgnjn = 7'h11,
		flt_sgnjx = 7'h12,
		flt_sign  = 7'h14,
		flt_sig   = 7'h15,
		flt_rm    = 7'h1C
	} func_e;

	// Second step of a fused op, code 5 has no meaning
	typedef enum logic [2:0] {
		cb_and   = 3'd0,
		cb_or    = 3'd1,
		cb_xor   = 3'd2,
		cb_add   = 3'd3,
		cb_shl   = 3'd4,
		cb_sel_t = 3'd6,
		cb_sel_b = 3'd7
	} combine_e;

	// ==================================================
	// Request, status and result payloads
	// ==================================================
	typedef struct packed {
		opcode_e  opcode;
		func_e    func;
		combine_e op3;
		logic     upd_status;  // Write class flags or rm
	} micro_op_t;

	typedef struct packed {
		micro_op_t         uop;
		logic [data_w-1:0] a;
		logic [data_w-1:0] b;
		logic [data_w-1:0] c;
		logic [data_w-1:0] t;    // Target, passed through by nop
		logic [data_w-1:0] imm;
	} fu_req_t;

	typedef struct packed {
		logic [2:0] rm;    // Rounding mode
		logic       neg;
		logic       pos;
		logic       zero;
		logic       inf;
		logic       c;     // Denormal, negative zero or quiet NaN
	} fp_status_t;

	typedef struct packed {
		fp64_t sgnj;
		fp64_t sgnjn;
		fp64_t sgnjx;
		fp64_t sign;
		fp64_t sig;
	} sign_res_t;

endpackage

// File: design/fpu_unit_top.sv
/*
 * Execution unit top level
 *   request and valid pipes, sign ops, integer ALU
 *   result stage and status register
 */

`timescale 1ns/10ps

module fpu_unit_top (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       req_valid,
	input  fpu_pkg::fu_req_t           req,
	output logic                       rsp_valid,
	output logic [fpu_pkg::data_w-1:0] result,
	output fpu_pkg::fp_status_t        status
);

	import fpu_pkg::*;

	fu_req_t           req_d;
	logic              req_valid_d;
	sign_res_t         sign_res;
	logic [data_w-1:0] int_result;
	logic              status_we;
	fp_status_t        status_next;

	// ==================================================
	// Operand delay
	// ==================================================
	stage_pipe #(.payload_t(fu_req_t), .depth(pipe_depth)) req_pipe_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.in     (req),
		.out    (req_d)
	);

	stage_pipe #(.payload_t(logic), .depth(pipe_depth)) valid_pipe_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.in     (req_valid),
		.out    (req_valid_d)
	);

	fp_sign_ops fp_sign_ops_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.a      (fp64_t'(req.a)),
		.b      (fp64_t'(req.b)),
		.res    (sign_res)
	);

	int_fused_alu int_fused_alu_inst (
		.req    (req_d),
		.result (int_result)
	);

	// ==================================================
	// Result and status
	// ==================================================
	result_select result_select_inst (
		.clk         (clk),
		.arst_n      (arst_n),
		.req_valid_d (req_valid_d),
		.req_d       (req_d),
		.int_result  (int_result),
		.sign_res    (sign_res),
		.status      (status),
		.status_we   (status_we),
		.status_next (status_next),
		.rsp_valid   (rsp_valid),
		.result      (result)
	);

	fp_status_regs fp_status_regs_inst (
		.clk         (clk),
		.arst_n      (arst_n),
		.status_we   (status_we),
		.status_next (status_next),
		.status      (status)
	);

endmodule

// File: design/int_fused_alu.sv
/*
 * Integer operations on the delayed request
 *   immediate add, subtract-from, and, or, xor
 *   fused three-operand ops with an op3 combine step
 */

`timescale 1ns/10ps

module int_fused_alu (
	input  fpu_pkg::fu_req_t          req,
	output logic [fpu_pkg::data_w-1:0] result
);

	import fpu_pkg::*;

	logic [data_w-1:0] part;      // a op b
	logic              part_ok;   // Known func
	logic [data_w-1:0] fused;
	logic              c_nz;

	assign c_nz = |req.c;

	// ==================================================
	// First step, a with b
	// ==================================================
	always_comb
	begin
		part    = '0;
		part_ok = 1'b1;
		case (req.uop.func)
			fn_add: part = req.a + req.b;
			fn_and: part = req.a & req.b;
			fn_or:  part = req.a | req.b;
			fn_xor: part = req.a ^ req.b;
			default: part_ok = 1'b0;
		endcase
	end

	// ==================================================
	// Combine step with c
	// ==================================================
	always_comb
	begin
		fused = '0;
		if (part_ok)
		begin
			case (req.uop.op3)
				cb_and:   fused = part & req.c;
				cb_or:    fused = part | req.c;
				cb_xor:   fused = part ^ req.c;
				cb_add:   fused = part + req.c;
				cb_shl:   fused = part << req.c;      // Large c clears all
				cb_sel_t: fused = c_nz ? part : req.t;
				cb_sel_b: fused = c_nz ? part : req.b;
				default:  fused = '0;                 // Code 5
			endcase
		end
	end

	always_comb
	begin
		case (req.uop.opcode)
			op_addi:  result = req.a + req.imm;
			op_subfi: result = req.imm - req.a;
			op_andi:  result = req.a & req.imm;
			op_ori:   result = req.a | req.imm;
			op_xori:  result = req.a ^ req.imm;
			op_r3o:   result = fused;
			default:  result = '0;
		endcase
	end

endmodule

// File: design/result_select.sv
/*
 * Result stage
 *   result multiplexer over integer, sign and status sources
 *   class flags and rounding-mode update for the status register
 *   output register for result and rsp_valid
 */

`timescale 1ns/10ps

module result_select (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       req_valid_d,
	input  fpu_pkg::fu_req_t           req_d,
	input  logic [fpu_pkg::data_w-1:0] int_result,
	input  fpu_pkg::sign_res_t         sign_res,
	input  fpu_pkg::fp_status_t        status,
	output logic                       status_we,
	output fpu_pkg::fp_status_t        status_next,
	output logic                       rsp_valid,
	output logic [fpu_pkg::data_w-1:0] result
);

	import fpu_pkg::*;

	logic [data_w-1:0] sel_c;
	fp64_t             cls_src;    // Value that is classified
	logic              cls_en;     // func sets class flags
	logic              is_flt;
	logic              mag_zero;

	assign is_flt = (req_d.uop.opcode == op_flt);

	// ==================================================
	// Result mux
	// ==================================================
	always_comb
	begin
		sel_c   = int_result;
		cls_src = sign_res.sgnj;
		cls_en  = 1'b0;
		if (is_flt)
		begin
			case (req_d.uop.func)
				flt_sgnj:  begin sel_c = sign_res.sgnj;  cls_src = sign_res.sgnj;  cls_en = 1'b1; end
				flt_sgnjn: begin sel_c = sign_res.sgnjn; cls_src = sign_res.sgnjn; cls_en = 1'b1; end
				flt_sgnjx: begin sel_c = sign_res.sgnjx; cls_src = sign_res.sgnjx; cls_en = 1'b1; end
				flt_sign:  begin sel_c = sign_res.sign;  cls_src = sign_res.sign;  cls_en = 1'b1; end
				flt_sig:   sel_c = sign_res.sig;
				flt_rm:    sel_c = {{(data_w-3){1'b0}}, status.rm};  // rm before any update
				default:   sel_c = '0;
			endcase
		end
		else if (req_d.uop.opcode == op_nop)
			sel_c = req_d.t;                 // Copy target
	end

	// ==================================================
	// Status update
	// ==================================================
	assign mag_zero = ({cls_src.exp, cls_src.sig} == '0);

	always_comb
	begin
		status_next = status;
		status_we   = 1'b0;
		if (req_valid_d && is_flt && req_d.uop.upd_status)
		begin
			if (cls_en)
			begin
				status_next.zero = mag_zero;
				status_next.neg  = cls_src.sign & ~mag_zero;
				status_next.pos  = ~cls_src.sign & ~mag_zero;
				status_next.inf  = (cls_src.exp == exp_max) && (cls_src.sig == '0);
				status_next.c    = ((cls_src.exp == '0) && (cls_src.sig != '0))        // Denormal
					| (cls_src.sign & mag_zero)                                      // -0
					| ((cls_src.exp == exp_max) && cls_src.sig[sig_w-1]);            // qNaN
				status_we = 1'b1;
			end
			else if (req_d.uop.func == flt_rm)
			begin
				status_next.rm = req_d.a[2:0];  // Flags kept
				status_we      = 1'b1;
			end
		end
	end

	// Output register
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			rsp_valid <= 1'b0;
		else
			rsp_valid <= req_valid_d;
	end

	always_ff @(posedge clk)
	begin
		result <= sel_c;
	end

endmodule

// File: design/stage_pipe.sv
/*
 * Fixed-depth register pipe
 *   payload given as a type parameter
 */

`timescale 1ns/10ps

module stage_pipe #(
	parameter type payload_t = logic,
	parameter int  depth     = fpu_pkg::pipe_depth
) (
	input  logic     clk,
	input  logic     arst_n,
	input  payload_t in,
	output payload_t out
);

	payload_t stage_q [depth];

	generate
		if ($bits(payload_t) == 1)
		begin : g_ctrl
			// Valid style chain, cleared on reset
			always_ff @(posedge clk or negedge arst_n)
			begin
				if (!arst_n)
				begin
					for (int i = 0; i < depth; i++)
						stage_q[i] <= '0;
				end
				else
				begin
					stage_q[0] <= in;
					for (int i = 1; i < depth; i++)
						stage_q[i] <= stage_q[i-1];
				end
			end
		end
		else
		begin : g_data
			always_ff @(posedge clk)
			begin
				stage_q[0] <= in;
				for (int i = 1; i < depth; i++)
					stage_q[i] <= stage_q[i-1];
			end
		end
	endgenerate

	assign out = stage_q[depth-1];  // Oldest entry

endmodule

// File: tb.f
+incdir+verification
design/fpu_pkg.sv
design/stage_pipe.sv
design/fp_sign_ops.sv
design/int_fused_alu.sv
design/fp_status_regs.sv
design/result_select.sv
design/fpu_unit_top.sv
verification/fpu_unit_tb.sv

// File: verification/fpu_unit_model.svh
/*
 * Reference model for the execution unit testbench
 *   Fibonacci LFSR random source
 *   expected result, class flags and status update
 */

`ifndef FPU_UNIT_MODEL_SVH
`define FPU_UNIT_MODEL_SVH

logic [31:0] lfsr_state = 32'd9;

// Taps 32, 22, 2, 1, one step per bit taken
function automatic logic [63:0] rand_bits(input int n);
	logic [63:0] v;
	logic        fb;
	v = '0;
	for (int i = 0; i < n; i++)
	begin
		fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		v          = {v[62:0], fb};
	end
	return v;
endfunction

function automatic fp_status_t class_flags(input logic [63:0] v);
	fp_status_t f;
	logic       mz;
	logic       e_ones;
	mz     = (v[62:0] == 63'h0);
	e_ones = (v[62:52] == 11'h7FF);
	f      = '0;
	f.zero = mz;
	f.neg  = v[63] && !mz;
	f.pos  = !v[63] && !mz;
	f.inf  = e_ones && (v[51:0] == 52'h0);
	f.c    = ((v[62:52] == 11'h0) && (v[51:0] != 52'h0)) || (v[63] && mz) || (e_ones && v[51]);
	return f;
endfunction

function automatic logic [63:0] expected_result(input fu_req_t r, input logic [2:0] rm);
	logic [63:0] p;
	logic        a_nan;
	a_nan = (r.a[62:52] == 11'h7FF) && (r.a[51:0] != 52'h0);
	case (r.uop.opcode)
		op_addi:  return r.a + r.imm;
		op_subfi: return r.imm - r.a;
		op_andi:  return r.a & r.imm;
		op_ori:   return r.a | r.imm;
		op_xori:  return r.a ^ r.imm;
		op_nop:   return r.t;
		op_r3o:
		begin
			case (r.uop.func)
				fn_add:  p = r.a + r.b;
				fn_and:  p = r.a & r.b;
				fn_or:   p = r.a | r.b;
				fn_xor:  p = r.a ^ r.b;
				default: return 64'h0;
			endcase
			case (r.uop.op3)
				cb_and:   return p & r.c;
				cb_or:    return p | r.c;
				cb_xor:   return p ^ r.c;
				cb_add:   return p + r.c;
				cb_shl:   return p << r.c;
				cb_sel_t: return (r.c != 64'h0) ? p : r.t;
				cb_sel_b: return (r.c != 64'h0) ? p : r.b;
				default:  return 64'h0;
			endcase
		end
		op_flt:
		begin
			case (r.uop.func)
				flt_sgnj:  return {r.a[63], r.b[62:0]};
				flt_sgnjn: return {~r.a[63], r.b[62:0]};
				flt_sgnjx: return {r.a[63] ^ r.b[63], r.b[62:0]};
				flt_sig:   return {12'h0, r.a[51:0]};
				flt_rm:    return {61'h0, rm};
				flt_sign:
				begin
					if (r.a[62:0] == 63'h0)
						return 64'h0;
					else if (a_nan)
						return r.a;
					else
						return {r.a[63], 63'h3FF0_0000_0000_0000};  // +/-1.0
				end
				default:   return 64'h0;
			endcase
		end
		default:  return 64'h0;
	endcase
endfunction

function automatic fp_status_t next_status(input fu_req_t r, input fp_status_t s,
	input logic [63:0] res);
	fp_status_t n;
	n = s;
	if (r.uop.opcode == op_flt && r.uop.upd_status)
	begin
		if (r.uop.func inside {flt_sgnj, flt_sgnjn, flt_sgnjx, flt_sign})
		begin
			n    = class_flags(res);
			n.rm = s.rm;                  // rm untouched by classification
		end
		else if (r.uop.func == flt_rm)
			n.rm = r.a[2:0];
	end
	return n;
endfunction

`endif

// File: verification/fpu_unit_tb.sv
/*
 * Testbench for the execution unit
 *   clock, reset and request driver
 *   expectation queue checked by concurrent assertions
 *   directed and LFSR driven tests with report
 */

`timescale 1ns/10ps

module fpu_unit_tb;

	import fpu_pkg::*;
	`include "fpu_unit_model.svh"

	logic              clk;
	logic              arst_n;
	logic              req_valid;
	fu_req_t           req;
	logic              rsp_valid;
	logic [data_w-1:0] result;
	fp_status_t        status;

	logic [data_w-1:0] exp_q [$];
	fp_status_t        stat_q [$];
	logic [data_w-1:0] head_result;
	fp_status_t        head_status;
	logic              head_ok;
	fp_status_t        model_status;
	int                errors;
	int                test_mark;
	int                tests_run;
	int                tests_failed;

	opcode_e     imm_ops [5]  = '{op_addi, op_subfi, op_andi, op_ori, op_xori};
	func_e       fused_fns [4] = '{fn_add, fn_and, fn_or, fn_xor};
	func_e       inj_fns [3]  = '{flt_sgnj, flt_sgnjn, flt_sgnjx};
	logic [63:0] specials [7] = '{64'h0, 64'h8000_0000_0000_0000, 64'h7FF0_0000_0000_0000,
		64'hFFF0_0000_0000_0000, 64'h7FF8_0000_0000_0000, 64'h7FF0_0000_0000_0001,
		64'h0000_0000_0000_0001};

	always #5 clk = ~clk;

	fpu_unit_top fpu_unit_top_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.req_valid (req_valid),
		.req       (req),
		.rsp_valid (rsp_valid),
		.result    (result),
		.status    (status)
	);

	// ==================================================
	// Expectation queue and checks
	// ==================================================
	always @(posedge clk)
	begin
		if (rsp_valid && exp_q.size() != 0)
		begin
			void'(exp_q.pop_front());
			void'(stat_q.pop_front());
		end
	end

	always @(negedge clk)
	begin
		head_ok = (exp_q.size() != 0);
		if (head_ok)
		begin
			head_result = exp_q[0];
			head_status = stat_q[0];
		end
	end

	// Driving edge to response edge is three edges
	latency_check: assert property (@(posedge clk) disable iff (!arst_n)
		rsp_valid == $past(req_valid, 3))
	else
	begin
		errors++;
		$display("%0t: rsp_valid does not follow the request by three edges", $time);
	end

	orphan_check: assert property (@(posedge clk) disable iff (!arst_n) rsp_valid |-> head_ok)
	else
	begin
		errors++;
		$display("%0t: a response came with no request outstanding", $time);
	end

	result_check: assert property (@(posedge clk) disable iff (!arst_n)
		rsp_valid |-> result == head_result)
	else
	begin
		errors++;
		$display("ERROR %0t: result %h, expected %h", $time, $sampled(result), head_result);
	end

	status_check: assert property (@(posedge clk) disable iff (!arst_n)
		rsp_valid |-> status == head_status)
	else
	begin
		errors++;
		$display("ERROR %0t: status %b, expected %b", $time, $sampled(status), head_status);
	end

	// ==================================================
	// Driver and report
	// ==================================================
	function automatic fu_req_t rand_req(input opcode_e op, input func_e fn, input combine_e cb,
		input logic upd);
		fu_req_t r;
		r.uop.opcode     = op;
		r.uop.func       = fn;
		r.uop.op3        = cb;
		r.uop.upd_status = upd;
		r.a              = rand_bits(64);
		r.b              = rand_bits(64);
		r.c              = rand_bits(64);
		r.t              = rand_bits(64);
		r.imm            = rand_bits(64);
		return r;
	endfunction

	task automatic send(input fu_req_t r);
		logic [data_w-1:0] res;
		@(posedge clk);
		req       <= r;
		req_valid <= 1'b1;
		res          = expected_result(r, model_status.rm);
		model_status = next_status(r, model_status, res);  // Program order
		exp_q.push_back(res);
		stat_q.push_back(model_status);
	endtask

	task automatic finish_test(input string name);
		int n;
		@(posedge clk);
		req_valid <= 1'b0;
		n = 0;
		while (exp_q.size() != 0 && n < 20)
		begin
			@(posedge clk);
			n++;
		end
		@(negedge clk);                  // Let the last checks settle
		if (exp_q.size() != 0)
		begin
			$display("Timeout in %s, %0d responses never arrived", name, exp_q.size());
			errors++;
			exp_q.delete();
			stat_q.delete();
		end
		tests_run++;
		if (errors != test_mark)
			tests_failed++;
		$display("[%s] %s with %0d errors", name, (errors != test_mark) ? "failed" : "passed",
			errors - test_mark);
		test_mark = errors;
	endtask

	initial
	begin
		fu_req_t r;
		clk          = 1'b0;
		arst_n       = 1'b0;
		req_valid    = 1'b0;
		req          = '0;
		head_ok      = 1'b0;
		model_status = '0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);
		assert (rsp_valid == 1'b0)
		else
		begin
			errors++;
			$display("ERROR %0t: rsp_valid high after reset", $time);
		end
		test_mark = errors;

		send(rand_req(op_addi, fn_add, cb_and, 1'b0));
		finish_test("latency");
		for (int i = 0; i < 8; i++)
			send(rand_req(imm_ops[i % 5], fn_add, cb_and, 1'b0));
		finish_test("burst");

		for (int i = 0; i < 20; i++)
			send(rand_req(imm_ops[i % 5], fn_add, cb_and, 1'b0));
		finish_test("immediate");

		// Random, zero and small c for every func and op3
		for (int f = 0; f < 4; f++)
		begin
			for (int k = 0; k < 8; k++)
			begin
				r = rand_req(op_r3o, fused_fns[f], combine_e'(k), 1'b0);
				send(r);
				r.c = '0;
				send(r);
				r.c = rand_bits(6);
				send(r);
			end
		end
		finish_test("fused");

		for (int s = 0; s < 7; s++)
		begin
			for (int f = 0; f < 3; f++)
			begin
				r   = rand_req(op_flt, inj_fns[f], cb_and, 1'b1);
				r.b = specials[s];
				send(r);
				r.a = specials[(s + 3) % 7];
				send(r);
			end
		end
		for (int i = 0; i < 6; i++)
			send(rand_req(op_flt, inj_fns[i % 3], cb_and, i[0]));  // Even ones keep status
		finish_test("sign inject");

		for (int s = 0; s < 13; s++)
		begin
			r = rand_req(op_flt, flt_sign, cb_and, 1'b1);
			if (s < 7)
				r.a = specials[s];
			send(r);
			r.uop.func = flt_sig;
			send(r);
		end
		finish_test("sign func");

		for (int i = 0; i < 6; i++)
			send(rand_req(op_flt, flt_rm, cb_and, (i != 4)));
		for (int i = 0; i < 4; i++)
			send(rand_req(op_nop, fn_add, cb_and, 1'b0));
		finish_test("rm and nop");

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule
